// ==== sources.f ====
logic/mem_access_pkg.sv
logic/mem_access_router.sv
logic/data_sram.sv
logic/peri_bus_master.sv
logic/mem_stage_top.sv
test/peri_slave_model.sv
test/mem_stage_asserts.sv
test/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - target: rtl
    files:
      - logic/mem_access_pkg.sv
      - logic/mem_access_router.sv
      - logic/data_sram.sv
      - logic/peri_bus_master.sv
      - logic/mem_stage_top.sv
  - target: test
    files:
      - test/peri_slave_model.sv
      - test/mem_stage_asserts.sv
      - test/tb_mem_stage.sv

// ==== test/tb_mem_stage.sv ====
// Memory stage testbench
// Random RAM and peripheral traffic checked against shadow models
`timescale 1ns/10ps

module tb_mem_stage import mem_access_pkg::*;
();

	localparam logic [31:0] SEED       = 32'hd231;
	localparam logic [31:0] ERR_LO     = 32'h0000_F000;
	localparam logic [31:0] ERR_HI     = 32'h0000_FFFF;
	localparam logic [31:0] FILL       = 32'hC0DE_0000;
	localparam int          WAIT_LIMIT = 16;
	localparam int          RAM_OPS    = 32;
	localparam int          PERI_OPS   = 24;
	localparam int          ERR_OPS    = 8;
	localparam int          DROP_OPS   = 6;
	localparam int          MIX_OPS    = 200;

	logic              clk;
	logic              rst_n;
	logic              i_req;
	logic              i_write;
	logic [ADDR_W-1:0] i_addr;
	logic [DATA_W-1:0] i_wdata;
	logic              o_rvalid;
	logic [DATA_W-1:0] o_rdata;
	logic              o_busy;
	logic              o_dec_err;
	logic [ADDR_W-1:0] haddr;
	htrans_e           htrans;
	logic              hwrite;
	hsize_e            hsize;
	hburst_e           hburst;
	logic [DATA_W-1:0] hwdata;
	logic [DATA_W-1:0] hrdata;
	logic              hreadyout;
	logic              hresp;

	// Shadow state
	logic [DATA_W-1:0] ram_model [SRAM_DEPTH];
	bit                ram_written [SRAM_DEPTH];
	logic [DATA_W-1:0] slave_model [64];
	logic [31:0]       lcg_state;
	logic [31:0]       drop_addr;
	bit                hung;
	int                checks;
	int                errors;
	int                tests;
	int                checks_mark;
	int                errors_mark;

	//====================
	// DUT and slave
	//====================

	mem_stage_top mem_stage_top_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.i_req       (i_req),
		.i_write     (i_write),
		.i_addr      (i_addr),
		.i_wdata     (i_wdata),
		.o_rvalid    (o_rvalid),
		.o_rdata     (o_rdata),
		.o_busy      (o_busy),
		.o_dec_err   (o_dec_err),
		.o_haddr     (haddr),
		.o_htrans    (htrans),
		.o_hwrite    (hwrite),
		.o_hsize     (hsize),
		.o_hburst    (hburst),
		.o_hwdata    (hwdata),
		.i_hrdata    (hrdata),
		.i_hreadyout (hreadyout),
		.i_hresp     (hresp)
	);

	peri_slave_model #(.SEED(SEED), .ERR_LO(ERR_LO), .ERR_HI(ERR_HI), .FILL(FILL))
	peri_slave_model_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.i_haddr     (haddr),
		.i_htrans    (htrans),
		.i_hwrite    (hwrite),
		.i_hwdata    (hwdata),
		.o_hrdata    (hrdata),
		.o_hreadyout (hreadyout),
		.o_hresp     (hresp)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//====================
	// Helpers
	//====================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Swap halves since upper LCG bits have the longer period
	function logic [31:0] rand_word();
		lcg_state = lcg_next(lcg_state);
		return {lcg_state[15:0], lcg_state[31:16]};
	endfunction

	function logic [31:0] ram_addr();
		return rand_word() & 32'h0000_7FFC;
	endfunction

	// Bit 12 cleared keeps clear of the error window
	function logic [31:0] peri_addr();
		return 32'h0000_8000 | (rand_word() & 32'hFFFF_6FFC);
	endfunction

	function logic [31:0] err_addr();
		return ERR_LO | (rand_word() & 32'h0000_0FFC);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %0d %s: %0d checks, %0d errors", tests + 1, name,
			checks - checks_mark, errors - errors_mark);
		tests++;
		checks_mark = checks;
		errors_mark = errors;
	endtask

	// One request from a falling edge back to a falling edge
	task automatic run_access(input logic wr, input logic [31:0] addr,
		input logic [31:0] wdata, input bit inject);
		logic [31:0] exp;
		bit          err;
		int          waited;
		if (hung)
			return;
		i_req   = 1'b1;
		i_write = wr;
		i_addr  = addr;
		i_wdata = wdata;
		@(negedge clk);
		i_req = 1'b0;
		if (addr < PERI_BASE)
		begin
			// RAM word back one cycle after the strobe
			check_value("o_rvalid", o_rvalid, !wr);
			if (wr)
			begin
				ram_model[addr[9:2]]   = wdata;
				ram_written[addr[9:2]] = 1'b1;
			end
			else
				check_value("o_rdata", o_rdata, ram_model[addr[9:2]]);
			return;
		end
		err = (addr >= ERR_LO) && (addr <= ERR_HI);
		exp = err ? '0 : slave_model[addr[7:2]];
		check_value("o_busy", o_busy, 1'b1);
		waited = 0;
		while (o_busy && waited < WAIT_LIMIT)
		begin
			check_value("o_rvalid", o_rvalid, 1'b0);
			check_value("o_dec_err", o_dec_err, 1'b0);
			// Request shown on the bus for the whole stall
			check_value("o_htrans", htrans, NONSEQ);
			check_value("o_haddr", haddr, addr);
			check_value("o_hwrite", hwrite, wr);
			if (wr)
				check_value("o_hwdata", hwdata, wdata);
			// AHB encodings for a single word transfer
			check_value("o_hsize", hsize, 3'b010);
			check_value("o_hburst", hburst, 3'b000);
			// RAM write strobed into the stall
			if (inject)
			begin
				i_req   = 1'b1;
				i_write = 1'b1;
				i_addr  = drop_addr;
				i_wdata = rand_word();
			end
			@(negedge clk);
			waited++;
		end
		i_req = 1'b0;
		if (o_busy)
		begin
			$display("timeout at %0t ns: o_busy still high after %0d cycles",
				$time, waited);
			errors++;
			hung = 1'b1;
			return;
		end
		// Results line up with busy falling
		check_value("o_rvalid", o_rvalid, !wr);
		check_value("o_dec_err", o_dec_err, err);
		if (!wr)
			check_value("o_rdata", o_rdata, exp);
		else if (!err)
			slave_model[addr[7:2]] = wdata;
	endtask

	//====================
	// Test sequence
	//====================

	initial
	begin
		logic [31:0] addrs [$];
		logic [31:0] a;
		logic [31:0] r;
		int          total;
		rst_n       = 1'b0;
		i_req       = 1'b0;
		i_write     = 1'b0;
		i_addr      = '0;
		i_wdata     = '0;
		lcg_state   = SEED;
		drop_addr   = '0;
		hung        = 1'b0;
		checks      = 0;
		errors      = 0;
		tests       = 0;
		checks_mark = 0;
		errors_mark = 0;
		for (int i = 0; i < 64; i++)
			slave_model[i] = FILL | (i << 2);
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		check_value("o_rvalid", o_rvalid, 1'b0);
		check_value("o_busy", o_busy, 1'b0);
		check_value("o_dec_err", o_dec_err, 1'b0);
		check_value("o_htrans", htrans, IDLE);
		finish_test("reset state");

		// Writes first and then reads of the same words
		repeat (RAM_OPS)
		begin
			a = ram_addr();
			addrs.push_back(a);
			run_access(1'b1, a, rand_word(), 1'b0);
		end
		foreach (addrs[k])
			run_access(1'b0, addrs[k], '0, 1'b0);
		finish_test("ram access");

		addrs.delete();
		repeat (PERI_OPS)
		begin
			a = peri_addr();
			addrs.push_back(a);
			run_access(1'b1, a, rand_word(), 1'b0);
		end
		foreach (addrs[k])
			run_access(1'b0, addrs[k], '0, 1'b0);
		finish_test("peripheral access");

		repeat (ERR_OPS)
		begin
			a = err_addr();
			run_access(1'b1, a, rand_word(), 1'b0);
			// Alias outside the window shows the slave word untouched
			run_access(1'b0, a & 32'hFFFF_8FFF, '0, 1'b0);
			run_access(1'b0, a, '0, 1'b0);
		end
		finish_test("decode error");

		repeat (DROP_OPS)
		begin
			drop_addr = ram_addr();
			run_access(1'b1, drop_addr, rand_word(), 1'b0);
			r = rand_word();
			run_access(r[0], peri_addr(), rand_word(), 1'b1);
			run_access(1'b0, drop_addr, '0, 1'b0);
		end
		finish_test("dropped requests");

		repeat (MIX_OPS)
		begin
			r = rand_word();
			if (r[0])
				a = ram_addr();
			else if (r[3:1] == 3'd0)
				a = err_addr();
			else
				a = peri_addr();
			// Only read RAM words with a known value
			if (r[4] && (a >= PERI_BASE || ram_written[a[9:2]]))
				run_access(1'b0, a, '0, 1'b0);
			else
				run_access(1'b1, a, rand_word(), 1'b0);
		end
		finish_test("mixed traffic");

		total = errors +
			mem_stage_top_inst.peri_bus_master_inst.mem_stage_asserts_inst.fail_count;
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, total);
		if (total == 0 && !hung)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule : tb_mem_stage

// ==== test/mem_stage_asserts.sv ====
// Peripheral bus master protocol checks
// Bound into the bus master, checks reset state, hold, done and busy
`timescale 1ns/10ps

module mem_stage_asserts import mem_access_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_start,
	input  logic                 i_hreadyout,
	input  logic                 o_busy,
	input  logic                 o_done,
	input  htrans_e              o_htrans,
	input  logic [ADDR_W-1:0]    o_haddr,
	input  logic                 o_hwrite,
	input  logic [DATA_W-1:0]    o_hwdata
);

	// Failed checks so far
	int fail_count = 0;

	// Bus idle straight out of reset
	reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> (o_htrans == IDLE))
	else
	begin
		$error("htrans not IDLE after reset");
		fail_count++;
	end

	// Request held while the slave waits
	hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(o_htrans == NONSEQ && !i_hreadyout) |=>
		($stable(o_haddr) && $stable(o_hwrite) && $stable(o_hwdata)))
	else
	begin
		$error("address, direction or write data changed during a wait state");
		fail_count++;
	end

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n) o_done |=> !o_done)
	else
	begin
		$error("done held high for more than one cycle");
		fail_count++;
	end

	// Busy only ever follows a start
	busy_start: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(o_busy) |-> $past(i_start))
	else
	begin
		$error("busy rose without a start");
		fail_count++;
	end

endmodule : mem_stage_asserts

bind peri_bus_master mem_stage_asserts mem_stage_asserts_inst (.*);

// ==== test/peri_slave_model.sv ====
// Behavioral peripheral bus slave
// Random wait states per transfer, 64-word memory, error response window
`timescale 1ns/10ps

module peri_slave_model import mem_access_pkg::*;
#(
	parameter logic [31:0] SEED   = 32'hd231,
	parameter logic [31:0] ERR_LO = 32'h0000_F000,
	parameter logic [31:0] ERR_HI = 32'h0000_FFFF,
	parameter logic [31:0] FILL   = 32'hC0DE_0000
)
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [ADDR_W-1:0]    i_haddr,
	input  htrans_e              i_htrans,
	input  logic                 i_hwrite,
	input  logic [DATA_W-1:0]    i_hwdata,
	output logic [DATA_W-1:0]    o_hrdata,
	output logic                 o_hreadyout,
	output logic                 o_hresp
);

	logic [DATA_W-1:0] mem [64];
	// Wait cycles left in the current transfer
	logic [1:0]        wait_cnt;
	logic [31:0]       lcg_state;
	logic [5:0]        idx;
	logic              in_err;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Word index aliases every 256 bytes
	assign idx    = i_haddr[7:2];
	assign in_err = (i_haddr >= ERR_LO) && (i_haddr <= ERR_HI);

	// Ready and error only on the completing cycle
	assign o_hreadyout = (wait_cnt == 2'd0);
	assign o_hresp     = o_hreadyout && (i_htrans == NONSEQ) && in_err;
	assign o_hrdata    = mem[idx];

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wait_cnt  <= 2'd0;
			lcg_state <= SEED;
			// Fill pattern from the word index
			for (int i = 0; i < 64; i++)
				mem[i] <= FILL | (i << 2);
		end
		else if (i_htrans == NONSEQ)
		begin
			if (wait_cnt != 2'd0)
				wait_cnt <= wait_cnt - 2'd1;
			else
			begin
				// Error window writes are discarded
				if (i_hwrite && !in_err)
					mem[idx] <= i_hwdata;
				// Wait states for the next transfer
				lcg_state <= lcg_next(lcg_state);
				wait_cnt  <= lcg_state[17:16];
			end
		end
	end

endmodule : peri_slave_model

// ==== logic/mem_stage_top.sv ====
// Memory access stage top level
// Router, local data RAM and peripheral bus master
`timescale 1ns/10ps

module mem_stage_top import mem_access_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	// Load/store request
	input  logic                 i_req,
	input  logic                 i_write,
	input  logic [ADDR_W-1:0]    i_addr,
	input  logic [DATA_W-1:0]    i_wdata,
	// Return and stall
	output logic                 o_rvalid,
	output logic [DATA_W-1:0]    o_rdata,
	output logic                 o_busy,
	output logic                 o_dec_err,
	// Peripheral bus
	output logic [ADDR_W-1:0]    o_haddr,
	output htrans_e              o_htrans,
	output logic                 o_hwrite,
	output hsize_e               o_hsize,
	output hburst_e              o_hburst,
	output logic [DATA_W-1:0]    o_hwdata,
	input  logic [DATA_W-1:0]    i_hrdata,
	input  logic                 i_hreadyout,
	input  logic                 i_hresp
);

	// Router to RAM
	logic                 sram_en;
	logic                 sram_we;
	logic [SRAM_AW-1:0]   sram_idx;
	logic [DATA_W-1:0]    sram_wdata;
	logic [DATA_W-1:0]    sram_rdata;
	// Router to master
	logic                 peri_start;
	logic                 peri_write;
	logic [ADDR_W-1:0]    peri_addr;
	logic [DATA_W-1:0]    peri_wdata;
	logic                 peri_busy;
	logic                 peri_done;
	logic [DATA_W-1:0]    peri_rdata;

	mem_access_router mem_access_router_inst
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.i_req        (i_req),
		.i_write      (i_write),
		.i_addr       (i_addr),
		.i_wdata      (i_wdata),
		.i_sram_rdata (sram_rdata),
		.o_sram_en    (sram_en),
		.o_sram_we    (sram_we),
		.o_sram_idx   (sram_idx),
		.o_sram_wdata (sram_wdata),
		.i_peri_busy  (peri_busy),
		.i_peri_done  (peri_done),
		.i_peri_rdata (peri_rdata),
		.o_peri_start (peri_start),
		.o_peri_write (peri_write),
		.o_peri_addr  (peri_addr),
		.o_peri_wdata (peri_wdata),
		.o_rvalid     (o_rvalid),
		.o_rdata      (o_rdata),
		.o_busy       (o_busy)
	);

	data_sram data_sram_inst
	(
		.clk     (clk),
		.i_en    (sram_en),
		.i_we    (sram_we),
		.i_idx   (sram_idx),
		.i_wdata (sram_wdata),
		.o_rdata (sram_rdata)
	);

	// Bus ports go straight out
	peri_bus_master peri_bus_master_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.i_start     (peri_start),
		.i_write     (peri_write),
		.i_addr      (peri_addr),
		.i_wdata     (peri_wdata),
		.o_busy      (peri_busy),
		.o_done      (peri_done),
		.o_rdata     (peri_rdata),
		.o_dec_err   (o_dec_err),
		.o_haddr     (o_haddr),
		.o_htrans    (o_htrans),
		.o_hwrite    (o_hwrite),
		.o_hsize     (o_hsize),
		.o_hburst    (o_hburst),
		.o_hwdata    (o_hwdata),
		.i_hrdata    (i_hrdata),
		.i_hreadyout (i_hreadyout),
		.i_hresp     (i_hresp)
	);

endmodule : mem_stage_top

// ==== logic/peri_bus_master.sv ====
// Peripheral bus master
// Runs one single transfer on an AHB-like bus per start strobe,
// stalls until the slave answers, reports error responses
`timescale 1ns/10ps

module peri_bus_master import mem_access_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	// Request from the router
	input  logic                 i_start,
	input  logic                 i_write,
	input  logic [ADDR_W-1:0]    i_addr,
	input  logic [DATA_W-1:0]    i_wdata,
	// Status back to the router
	output logic                 o_busy,
	output logic                 o_done,
	output logic [DATA_W-1:0]    o_rdata,
	output logic                 o_dec_err,
	// Bus, master driven
	output logic [ADDR_W-1:0]    o_haddr,
	output htrans_e              o_htrans,
	output logic                 o_hwrite,
	output hsize_e               o_hsize,
	output hburst_e              o_hburst,
	output logic [DATA_W-1:0]    o_hwdata,
	// Bus, slave driven
	input  logic [DATA_W-1:0]    i_hrdata,
	input  logic                 i_hreadyout,
	input  logic                 i_hresp
);

	peri_state_e state;
	peri_state_e state_nxt;
	// Slave accepted the transfer this cycle
	logic        xfer_end;

	//====================
	// FSM
	//====================

	assign xfer_end = (state == ST_NONSEQ) & i_hreadyout;

	always_comb
	begin
		state_nxt = state;
		unique case (state)
			ST_IDLE:
			begin
				if (i_start)
					state_nxt = ST_NONSEQ;
			end
			ST_NONSEQ:
			begin
				// Hold NONSEQ through wait states
				if (i_hreadyout)
					state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	//====================
	// Request latch
	//====================

	// Direction latch, only loaded when idle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_hwrite <= 1'b0;
		else if ((state == ST_IDLE) && i_start)
			o_hwrite <= i_write;
	end

	// Address and data stay put while the slave waits
	always_ff @(posedge clk)
	begin
		if ((state == ST_IDLE) && i_start)
		begin
			o_haddr  <= i_addr;
			o_hwdata <= i_wdata;
		end
	end

	//====================
	// Completion
	//====================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			o_done    <= 1'b0;
			o_dec_err <= 1'b0;
		end
		else
		begin
			// One-cycle pulses, line up with busy falling
			o_done    <= xfer_end;
			o_dec_err <= xfer_end & i_hresp;
		end
	end

	// Zero data on an error response
	always_ff @(posedge clk)
	begin
		if (xfer_end)
			o_rdata <= i_hresp ? '0 : i_hrdata;
	end

	//====================
	// Bus outputs
	//====================

	assign o_busy   = (state == ST_NONSEQ);
	assign o_htrans = (state == ST_NONSEQ) ? NONSEQ : IDLE;
	// Single word transfers only
	assign o_hsize  = WORD;
	assign o_hburst = SINGLE;

endmodule : peri_bus_master

// ==== logic/data_sram.sv ====
// Local data RAM
// Single port, word wide, synchronous write and registered read
`timescale 1ns/10ps

module data_sram import mem_access_pkg::*;
(
	input  logic                 clk,
	// Access strobe and direction
	input  logic                 i_en,
	input  logic                 i_we,
	// Word index and write word
	input  logic [SRAM_AW-1:0]   i_idx,
	input  logic [DATA_W-1:0]    i_wdata,
	// Read word, valid one cycle after a read
	output logic [DATA_W-1:0]    o_rdata
);

	//====================
	// Storage
	//====================

	// Contents start undefined
	logic [DATA_W-1:0] mem [SRAM_DEPTH];

	//====================
	// Access port
	//====================

	always_ff @(posedge clk)
	begin
		if (i_en)
		begin
			if (i_we)
			begin
				// Whole word store
				mem[i_idx] <= i_wdata;
			end
			else
			begin
				// Read data held until the next read
				o_rdata <= mem[i_idx];
			end
		end
	end

endmodule : data_sram

// ==== logic/mem_access_router.sv ====
// Memory stage request router
// Steers each accepted request to the data RAM or the peripheral master
// and merges both read returns onto one valid/data pair
`timescale 1ns/10ps

module mem_access_router import mem_access_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	// Requester side
	input  logic                 i_req,
	input  logic                 i_write,
	input  logic [ADDR_W-1:0]    i_addr,
	input  logic [DATA_W-1:0]    i_wdata,
	// Data RAM side
	input  logic [DATA_W-1:0]    i_sram_rdata,
	output logic                 o_sram_en,
	output logic                 o_sram_we,
	output logic [SRAM_AW-1:0]   o_sram_idx,
	output logic [DATA_W-1:0]    o_sram_wdata,
	// Peripheral master side
	input  logic                 i_peri_busy,
	input  logic                 i_peri_done,
	input  logic [DATA_W-1:0]    i_peri_rdata,
	output logic                 o_peri_start,
	output logic                 o_peri_write,
	output logic [ADDR_W-1:0]    o_peri_addr,
	output logic [DATA_W-1:0]    o_peri_wdata,
	// Read return and stall
	output logic                 o_rvalid,
	output logic [DATA_W-1:0]    o_rdata,
	output logic                 o_busy
);

	logic accept;
	logic addr_is_peri;
	// RAM read issued last cycle
	logic sram_rd_q;
	// Outstanding peripheral access is a read
	logic peri_rd_q;

	//====================
	// Accept and decode
	//====================

	// Requests during a peripheral stall are dropped
	assign accept       = i_req & ~i_peri_busy;
	assign addr_is_peri = (i_addr >= PERI_BASE);

	// RAM port, word index from bits 9:2
	assign o_sram_en    = accept & ~addr_is_peri;
	assign o_sram_we    = i_write;
	assign o_sram_idx   = i_addr[SRAM_AW+1:2];
	assign o_sram_wdata = i_wdata;

	// Peripheral start strobe with its payload
	assign o_peri_start = accept & addr_is_peri;
	assign o_peri_write = i_write;
	assign o_peri_addr  = i_addr;
	assign o_peri_wdata = i_wdata;

	//====================
	// Read return
	//====================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sram_rd_q <= 1'b0;
			peri_rd_q <= 1'b0;
		end
		else
		begin
			// RAM word comes back one cycle after the read
			sram_rd_q <= o_sram_en & ~i_write;
			// Direction kept for the whole peripheral access
			if (o_peri_start)
				peri_rd_q <= ~i_write;
		end
	end

	// Never both at once, peripheral access blocks new requests
	assign o_rvalid = sram_rd_q | (i_peri_done & peri_rd_q);
	assign o_rdata  = sram_rd_q ? i_sram_rdata : i_peri_rdata;

	// Stall follows the master
	assign o_busy = i_peri_busy;

endmodule : mem_access_router

// ==== logic/mem_access_pkg.sv ====
// Memory access stage shared definitions
// Widths, peripheral boundary, RAM geometry and bus encodings
package mem_access_pkg;

	//====================
	// Datapath widths
	//====================

	// Word-wide data path only
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	//====================
	// Address map
	//====================

	// At or above this address goes to the peripheral bus
	localparam logic [ADDR_W-1:0] PERI_BASE = 32'h0000_8000;

	// Local data RAM, word indexed by address bits 9:2
	localparam int SRAM_DEPTH = 256;
	localparam int SRAM_AW    = 8;

	//====================
	// Peripheral bus encodings
	//====================

	// Transfer type, single transfers only
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		NONSEQ = 2'b10
	} htrans_e;

	// Transfer size, whole words only
	typedef enum logic [2:0] {
		WORD = 3'b010
	} hsize_e;

	// Burst type, no bursts issued
	typedef enum logic [2:0] {
		SINGLE = 3'b000
	} hburst_e;

	// Bus master states
	typedef enum logic {
		ST_IDLE   = 1'b0,
		ST_NONSEQ = 1'b1
	} peri_state_e;

endpackage : mem_access_pkg
